// ==== build.f ====
logic/ssc_pkg.sv
logic/card_checker.sv
logic/cost_sorter.sv
logic/change_calc.sv
logic/ssc_top.sv
test/ssc_tb.sv

// ==== logic/card_checker.sv ====
// card checker: Luhn sum of the sixteen card digits with a registered verdict
module card_checker (
    input  logic           clk,
    input  logic           rst_n,
    input  ssc_pkg::card_t card_num,
    output logic           card_ok
);

    logic [7:0] luhn_sum;
    logic       sum_ok;
    logic       digits_ok;

    // digit idx counted from the left, digit 0 is the top nibble
    function automatic ssc_pkg::digit_t card_digit(
        input ssc_pkg::card_t card,
        input int             idx
    );
        return card[(ssc_pkg::NUM_DIGITS - 1 - idx) * ssc_pkg::DIGIT_W +: ssc_pkg::DIGIT_W];
    endfunction

    // digit sum of 2*d, i.e. 0 2 4 6 8 1 3 5 7 9
    function automatic ssc_pkg::digit_t doubled_sum(input ssc_pkg::digit_t d);
        ssc_pkg::digit_t dbl;
        dbl = ssc_pkg::digit_t'(d << 1);
        if (d >= ssc_pkg::digit_t'(5)) begin
            return dbl - ssc_pkg::digit_t'(9);
        end
        return dbl;
    endfunction

    // ============================================================
    // Luhn sum
    // ============================================================

    always_comb begin
        luhn_sum  = '0;
        digits_ok = 1'b1;
        for (int i = 0; i < ssc_pkg::NUM_DIGITS; i++) begin
            // even index from the left gets doubled
            if (i % 2 == 0) begin
                luhn_sum = luhn_sum + doubled_sum(card_digit(card_num, i));
            end else begin
                luhn_sum = luhn_sum + card_digit(card_num, i);
            end
            if (card_digit(card_num, i) > ssc_pkg::digit_t'(9)) begin
                digits_ok = 1'b0;
            end
        end
    end

    // multiple of ten inside the window
    assign sum_ok = (luhn_sum >= ssc_pkg::CARD_SUM_MIN) &&
                    (luhn_sum <= ssc_pkg::CARD_SUM_MAX) &&
                    (luhn_sum % ssc_pkg::CARD_MODULUS == 0);

    // stage 1 verdict
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            card_ok <= 1'b0;
        end else begin
            card_ok <= sum_ok;
        end
    end

    // card digits are decimal, the doubled-sum mapping is wrong otherwise
    a_card_digits_decimal : assert property (
        @(posedge clk) disable iff (!rst_n) digits_ok
    );

endmodule

// ==== logic/change_calc.sv ====
// change calculator: pays sorted costs from the money until one no longer fits
module change_calc (
    input  logic            clk,
    input  logic            rst_n,
    input  ssc_pkg::money_t input_money,
    input  logic            card_ok,
    input  ssc_pkg::cost_t  sorted_cost [0:ssc_pkg::NUM_ITEMS-1],
    output logic            out_valid,
    output ssc_pkg::money_t out_change
);

    ssc_pkg::money_t money_q;
    ssc_pkg::money_t remain;

    // ============================================================
    // stage 1 money, lines up with verdict and sorted costs
    // ============================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            money_q <= '0;
        end else begin
            money_q <= input_money;
        end
    end

    // ============================================================
    // greedy payment
    // ============================================================

    always_comb begin
        logic [9:0] diff;
        logic       stopped;
        remain  = money_q;
        stopped = 1'b0;
        for (int i = 0; i < ssc_pkg::NUM_ITEMS; i++) begin
            // one extra bit so a borrow shows up as bit 9
            diff = {1'b0, remain} - {2'b00, sorted_cost[i]};
            if (!stopped) begin
                if (diff[9]) begin
                    stopped = 1'b1;
                end else begin
                    remain = diff[8:0];
                end
            end
        end
    end

    // stage 2 outputs, rejected card hands back everything
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            out_change <= '0;
        end else begin
            out_valid  <= card_ok;
            out_change <= card_ok ? remain : money_q;
        end
    end

    // change is bounded by the money one stage back
    a_change_bounded : assert property (
        @(posedge clk) disable iff (!rst_n) out_change <= $past(money_q)
    );

endmodule

// ==== logic/cost_sorter.sv ====
// cost sorter: eight digit products ordered largest first by a compare-exchange network
module cost_sorter (
    input  logic               clk,
    input  logic               rst_n,
    input  ssc_pkg::item_vec_t snack_num,
    input  ssc_pkg::item_vec_t price,
    output ssc_pkg::cost_t     sorted_cost [0:ssc_pkg::NUM_ITEMS-1]
);

    // net[0] holds the raw products, net[k] the array after layer k
    ssc_pkg::cost_t net [0:6][0:ssc_pkg::NUM_ITEMS-1];

    // item idx from the left, item 0 is the top nibble
    function automatic ssc_pkg::digit_t item_digit(
        input ssc_pkg::item_vec_t vec,
        input int                 idx
    );
        return vec[(ssc_pkg::NUM_ITEMS - 1 - idx) * ssc_pkg::DIGIT_W +: ssc_pkg::DIGIT_W];
    endfunction

    // single digit multiplier
    function automatic ssc_pkg::cost_t digit_mul(
        input ssc_pkg::digit_t a,
        input ssc_pkg::digit_t b
    );
        return ssc_pkg::cost_t'(a) * ssc_pkg::cost_t'(b);
    endfunction

    // larger value goes to hi, ties keep their order
    function automatic void order_pair(
        input  ssc_pkg::cost_t a,
        input  ssc_pkg::cost_t b,
        output ssc_pkg::cost_t hi,
        output ssc_pkg::cost_t lo
    );
        if (a < b) begin
            hi = b;
            lo = a;
        end else begin
            hi = a;
            lo = b;
        end
    endfunction

    // ============================================================
    // products
    // ============================================================

    always_comb begin
        for (int i = 0; i < ssc_pkg::NUM_ITEMS; i++) begin
            net[0][i] = digit_mul(item_digit(snack_num, i), item_digit(price, i));
        end
    end

    // ============================================================
    // six-layer sort network
    // ============================================================

    always_comb begin
        // layer 1: (0,2) (1,3) (4,6) (5,7)
        net[1] = net[0];
        order_pair(net[0][0], net[0][2], net[1][0], net[1][2]);
        order_pair(net[0][1], net[0][3], net[1][1], net[1][3]);
        order_pair(net[0][4], net[0][6], net[1][4], net[1][6]);
        order_pair(net[0][5], net[0][7], net[1][5], net[1][7]);

        // layer 2: (0,4) (1,5) (2,6) (3,7)
        net[2] = net[1];
        order_pair(net[1][0], net[1][4], net[2][0], net[2][4]);
        order_pair(net[1][1], net[1][5], net[2][1], net[2][5]);
        order_pair(net[1][2], net[1][6], net[2][2], net[2][6]);
        order_pair(net[1][3], net[1][7], net[2][3], net[2][7]);

        // layer 3: neighbours
        net[3] = net[2];
        order_pair(net[2][0], net[2][1], net[3][0], net[3][1]);
        order_pair(net[2][2], net[2][3], net[3][2], net[3][3]);
        order_pair(net[2][4], net[2][5], net[3][4], net[3][5]);
        order_pair(net[2][6], net[2][7], net[3][6], net[3][7]);

        // layer 4: (2,4) (3,5)
        net[4] = net[3];
        order_pair(net[3][2], net[3][4], net[4][2], net[4][4]);
        order_pair(net[3][3], net[3][5], net[4][3], net[4][5]);

        // layer 5: (1,4) (3,6)
        net[5] = net[4];
        order_pair(net[4][1], net[4][4], net[5][1], net[5][4]);
        order_pair(net[4][3], net[4][6], net[5][3], net[5][6]);

        // layer 6: (1,2) (3,4) (5,6)
        net[6] = net[5];
        order_pair(net[5][1], net[5][2], net[6][1], net[6][2]);
        order_pair(net[5][3], net[5][4], net[6][3], net[6][4]);
        order_pair(net[5][5], net[5][6], net[6][5], net[6][6]);
    end

    // stage 1 sorted costs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ssc_pkg::NUM_ITEMS; i++) begin
                sorted_cost[i] <= '0;
            end
        end else begin
            sorted_cost <= net[6];
        end
    end

    // network output must come out largest first
    for (genvar g = 0; g < ssc_pkg::NUM_ITEMS - 1; g++) begin : g_order_chk
        a_sorted_desc : assert property (
            @(posedge clk) disable iff (!rst_n) sorted_cost[g] >= sorted_cost[g+1]
        );
    end

endmodule

// ==== logic/ssc_pkg.sv ====
// snack shopping calculator package: widths, digit types and card-check limits
package ssc_pkg;

    // ============================================================
    // sizes
    // ============================================================

    localparam int DIGIT_W    = 4;
    localparam int NUM_ITEMS  = 8;
    localparam int NUM_DIGITS = 16;

    // ============================================================
    // Luhn acceptance window
    // ============================================================

    // lowest and highest sums that still count as a real card
    localparam int CARD_SUM_MIN = 50;
    localparam int CARD_SUM_MAX = 120;
    localparam int CARD_MODULUS = 10;

    // ============================================================
    // types
    // ============================================================

    // one decimal digit, 0..9 in practice
    typedef logic [DIGIT_W-1:0] digit_t;

    // sixteen card digits, digit 0 in the top nibble
    typedef logic [NUM_DIGITS*DIGIT_W-1:0] card_t;

    // money in and change out
    typedef logic [8:0] money_t;

    // count times price, at most 81 for decimal digits
    typedef logic [7:0] cost_t;

    // eight digits, item 0 in the top nibble
    typedef logic [NUM_ITEMS*DIGIT_W-1:0] item_vec_t;

endpackage

// ==== logic/ssc_top.sv ====
// snack shopping calculator top: card check and cost sort feeding the change stage
module ssc_top (
    input  logic               clk,
    input  logic               rst_n,
    input  ssc_pkg::card_t     card_num,
    input  ssc_pkg::money_t    input_money,
    input  ssc_pkg::item_vec_t snack_num,
    input  ssc_pkg::item_vec_t price,
    output logic               out_valid,
    output ssc_pkg::money_t    out_change
);

    // ============================================================
    // stage 1 results
    // ============================================================

    logic           card_ok;
    ssc_pkg::cost_t sorted_cost [0:ssc_pkg::NUM_ITEMS-1];

    // Luhn verdict
    card_checker u_card_checker (
        .clk      (clk),
        .rst_n    (rst_n),
        .card_num (card_num),
        .card_ok  (card_ok)
    );

    // item costs, largest first
    cost_sorter u_cost_sorter (
        .clk         (clk),
        .rst_n       (rst_n),
        .snack_num   (snack_num),
        .price       (price),
        .sorted_cost (sorted_cost)
    );

    // ============================================================
    // stage 2
    // ============================================================

    // money goes straight in, its own register keeps it in step
    change_calc u_change_calc (
        .clk         (clk),
        .rst_n       (rst_n),
        .input_money (input_money),
        .card_ok     (card_ok),
        .sorted_cost (sorted_cost),
        .out_valid   (out_valid),
        .out_change  (out_change)
    );

endmodule

// ==== test/ssc_tb.sv ====
// snack shopping calculator testbench: directed and back-to-back checks against a model
module ssc_tb;

    localparam int CLK_PERIOD       = 4;
    localparam int RESET_CYCLES     = 3;
    localparam int DIRECTED_VECTORS = 9;
    localparam int NUM_RANDOM       = 40;
    localparam int TIMEOUT_CYCLES   = (DIRECTED_VECTORS + NUM_RANDOM) * 3 + RESET_CYCLES + 20;

    // Luhn sum 80, accepted
    localparam ssc_pkg::card_t VALID_CARD  = 64'h4539_1488_0343_6467;
    // same card with the check digit one off, sum 81
    localparam ssc_pkg::card_t BAD_CHECK   = 64'h4539_1488_0343_6468;
    // multiples of ten outside the window
    localparam ssc_pkg::card_t SUM40_CARD  = 64'h0505_0505_0505_0505;
    localparam ssc_pkg::card_t SUM130_CARD = 64'h9999_9999_9999_1919;

    logic               clk;
    logic               rst_n;
    ssc_pkg::card_t     card_num;
    ssc_pkg::money_t    input_money;
    ssc_pkg::item_vec_t snack_num;
    ssc_pkg::item_vec_t price;
    logic               out_valid;
    ssc_pkg::money_t    out_change;

    integer seed        = 32'h26e7_a537;
    int     error_count = 0;
    int     check_count = 0;
    int     tests_run   = 0;
    int     tests_bad   = 0;

    ssc_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .card_num    (card_num),
        .input_money (input_money),
        .snack_num   (snack_num),
        .price       (price),
        .out_valid   (out_valid),
        .out_change  (out_change)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ============================================================
    // reference model
    // ============================================================

    // digit 0 is the leftmost, doubled when its index is even
    function automatic int luhn_sum(input ssc_pkg::card_t card);
        int sum;
        int d;
        sum = 0;
        for (int i = 0; i < 16; i++) begin
            d = card[(15 - i) * 4 +: 4];
            if (i % 2 == 0) begin
                d = 2 * d;
                d = d / 10 + d % 10;
            end
            sum += d;
        end
        return sum;
    endfunction

    function automatic bit model_card_ok(input ssc_pkg::card_t card);
        int sum;
        sum = luhn_sum(card);
        return (sum % 10 == 0) && (sum >= 50) && (sum <= 120);
    endfunction

    function automatic int model_change(
        input ssc_pkg::card_t     card,
        input int                 money,
        input ssc_pkg::item_vec_t snack,
        input ssc_pkg::item_vec_t prc
    );
        int costs [8];
        int tmp;
        int remain;
        if (!model_card_ok(card)) begin
            return money;
        end
        for (int i = 0; i < 8; i++) begin
            costs[i] = snack[(7 - i) * 4 +: 4] * prc[(7 - i) * 4 +: 4];
        end
        // plain insertion sort, largest first
        for (int i = 1; i < 8; i++) begin
            for (int j = i; j > 0 && costs[j] > costs[j-1]; j--) begin
                tmp        = costs[j];
                costs[j]   = costs[j-1];
                costs[j-1] = tmp;
            end
        end
        remain = money;
        for (int i = 0; i < 8; i++) begin
            if (costs[i] > remain) begin
                break;
            end
            remain -= costs[i];
        end
        return remain;
    endfunction

    // ============================================================
    // drive and check helpers
    // ============================================================

    task automatic drive_inputs(
        input ssc_pkg::card_t     card,
        input int                 money,
        input ssc_pkg::item_vec_t snack,
        input ssc_pkg::item_vec_t prc
    );
        card_num    = card;
        input_money = ssc_pkg::money_t'(money);
        snack_num   = snack;
        price       = prc;
    endtask

    task automatic compare_outputs(input string name, input logic exp_valid, input int exp_change);
        check_count++;
        if (out_valid !== exp_valid) begin
            $display("ERR %s: out_valid expected %0d actual %0d", name, exp_valid, out_valid);
            error_count++;
        end
        if (out_change !== ssc_pkg::money_t'(exp_change)) begin
            $display("ERR %s: out_change expected %0d actual %0d", name, exp_change, out_change);
            error_count++;
        end
    endtask

    // called one time unit after an edge, checks two edges later
    task automatic apply_vector(
        input string              name,
        input ssc_pkg::card_t     card,
        input int                 money,
        input ssc_pkg::item_vec_t snack,
        input ssc_pkg::item_vec_t prc
    );
        drive_inputs(card, money, snack, prc);
        @(posedge clk);
        @(posedge clk);
        #1;
        compare_outputs(name, model_card_ok(card), model_change(card, money, snack, prc));
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %-14s ok", name);
        end else begin
            tests_bad++;
            $display("test %-14s %0d mismatches", name, error_count - errors_before);
        end
    endtask

    // ============================================================
    // tests
    // ============================================================

    task automatic test_reset_state();
        int start;
        start = error_count;
        compare_outputs("reset_state", 1'b0, 0);
        finish_test("reset_state", start);
    endtask

    task automatic test_card_check();
        int start;
        start = error_count;
        apply_vector("card_valid", VALID_CARD, 200, 32'h1111_1111, 32'h1234_5678);
        apply_vector("card_bad_check", BAD_CHECK, 200, 32'h1111_1111, 32'h1234_5678);
        apply_vector("card_sum_40", SUM40_CARD, 321, 32'h1111_1111, 32'h1234_5678);
        apply_vector("card_sum_130", SUM130_CARD, 77, 32'h1111_1111, 32'h1234_5678);
        finish_test("card_check", start);
    endtask

    task automatic test_greedy_change();
        int start;
        start = error_count;
        // costs 1..8, total 36
        apply_vector("all_fit", VALID_CARD, 100, 32'h1111_1111, 32'h1234_5678);
        // every cost 63
        apply_vector("none_fit", VALID_CARD, 62, 32'h9999_9999, 32'h7777_7777);
        // 9+8+7 paid, 6 does not fit and the later 2 is not taken
        apply_vector("partway", VALID_CARD, 26, 32'h1111_1111, 32'h9876_5432);
        finish_test("greedy_change", start);
    endtask

    task automatic test_ties_and_zeros();
        int start;
        start = error_count;
        // all eight costs equal to 6
        apply_vector("equal_costs", VALID_CARD, 40, 32'h2222_3333, 32'h3333_2222);
        apply_vector("zero_counts", VALID_CARD, 150, 32'h0000_0000, 32'h9876_5432);
        finish_test("ties_and_zeros", start);
    endtask

    task automatic test_back_to_back();
        int                 start;
        logic               exp_valid_q [$];
        int                 exp_change_q [$];
        ssc_pkg::card_t     card;
        ssc_pkg::item_vec_t snack;
        ssc_pkg::item_vec_t prc;
        int                 money;
        int                 partial;
        start = error_count;
        for (int i = 0; i < NUM_RANDOM + 2; i++) begin
            // output now belongs to the vector driven two edges ago
            if (i >= 2) begin
                compare_outputs($sformatf("random_%0d", i - 2),
                                exp_valid_q.pop_front(), exp_change_q.pop_front());
            end
            if (i < NUM_RANDOM) begin
                for (int d = 0; d < 16; d++) begin
                    card[d*4 +: 4] = $unsigned($random(seed)) % 10;
                end
                // even vectors get a matching check digit
                if (i % 2 == 0) begin
                    card[3:0] = 4'd0;
                    partial   = luhn_sum(card);
                    card[3:0] = (10 - partial % 10) % 10;
                end
                for (int d = 0; d < 8; d++) begin
                    snack[d*4 +: 4] = $unsigned($random(seed)) % 10;
                    prc[d*4 +: 4]   = $unsigned($random(seed)) % 10;
                end
                money = $random(seed) & 32'h1ff;
                drive_inputs(card, money, snack, prc);
                exp_valid_q.push_back(model_card_ok(card));
                exp_change_q.push_back(model_change(card, money, snack, prc));
            end
            @(posedge clk);
            #1;
        end
        finish_test("back_to_back", start);
    endtask

    // ============================================================
    // main sequence and watchdog
    // ============================================================

    initial begin
        rst_n = 1'b0;
        drive_inputs('0, 0, '0, '0);
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_state();
        test_card_check();
        test_greedy_change();
        test_ties_and_zeros();
        test_back_to_back();

        $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
                 tests_run, tests_bad, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
